// ==== logic/mipsPkg.sv ====
package mipsPkg;

	localparam int DataWidth = 32;
	localparam int AddrWidth = 9; // 512-byte memory space
	localparam int RegIdxWidth = 5;

	typedef logic [DataWidth-1:0] dataWord;
	typedef logic [AddrWidth-1:0] memAddr;
	typedef logic [RegIdxWidth-1:0] regIdx;

	// Opcodes
	localparam logic [5:0] OpRType = 6'h00;
	localparam logic [5:0] OpBeq = 6'h04;
	localparam logic [5:0] OpBne = 6'h05;
	localparam logic [5:0] OpAddi = 6'h08;
	localparam logic [5:0] OpSlti = 6'h0a;
	localparam logic [5:0] OpAndi = 6'h0c;
	localparam logic [5:0] OpOri = 6'h0d;
	localparam logic [5:0] OpXori = 6'h0e;
	localparam logic [5:0] OpLui = 6'h0f;
	localparam logic [5:0] OpLw = 6'h23;
	localparam logic [5:0] OpSw = 6'h2b;

	// R-type function codes
	localparam logic [5:0] FnSll = 6'h00;
	localparam logic [5:0] FnSrl = 6'h02;
	localparam logic [5:0] FnSra = 6'h03;
	localparam logic [5:0] FnAdd = 6'h20;
	localparam logic [5:0] FnSub = 6'h22;
	localparam logic [5:0] FnAnd = 6'h24;
	localparam logic [5:0] FnOr = 6'h25;
	localparam logic [5:0] FnXor = 6'h26;
	localparam logic [5:0] FnNor = 6'h27;
	localparam logic [5:0] FnSlt = 6'h2a;
	localparam logic [5:0] FnSltu = 6'h2b;

	typedef enum logic [3:0] {
		Idle,
		Fetch,
		Decode,
		ExecReg,
		ExecImm,
		Branch,
		MemAddr,
		LoadWait,
		LoadWrite,
		StoreWait
	} cpuState;

	typedef enum logic [2:0] {
		AluFunct, // Operation taken from funct field
		AluAdd,
		AluSlt,
		AluAnd,
		AluOr,
		AluXor,
		AluLui
	} aluSel;

	typedef enum logic [1:0] {SrcReg, SrcSignImm, SrcZeroImm, SrcShamt} aluSrcSel;

	typedef enum logic {InAlu, InMem} regInSel;

	typedef enum logic [1:0] {BrNone, BrEq, BrNe} branchKind;

	typedef struct packed {
		logic [5:0] opcode;
		regIdx rs;
		regIdx rt;
		regIdx rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat;

	typedef struct packed {
		logic [5:0] opcode;
		regIdx rs;
		regIdx rt;
		logic [15:0] imm;
	} iFormat;

	// Same fetched word viewed as R-type or I-type
	typedef union packed {
		rFormat rType;
		iFormat iType;
	} instrWord;

	typedef struct packed {
		logic pcWrite; // PC+4 in fetch, target in branch
		logic irLoad;
		logic regWrite;
		logic regDstRd; // 1 selects rd, 0 selects rt
		regInSel regIn;
		aluSrcSel aluSrc;
		aluSel alu;
		branchKind branch;
		logic marLoad; // Also loads store data
		logic memValid;
		logic memWrite;
	} ctrlWord;

	typedef struct packed {
		logic valid;
		logic write;
		memAddr addr;
		dataWord wdata;
	} memReq;

	typedef struct packed {
		logic done;
		dataWord rdata;
	} memRsp;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
	input mipsPkg::aluSel sel,
	input logic [5:0] funct,
	input mipsPkg::dataWord a,
	input mipsPkg::dataWord b,
	output mipsPkg::dataWord result
);

	logic [5:0] op;
	logic [4:0] shiftAmt;

	assign shiftAmt = b[4:0];

	// Immediate selects map onto the matching R-type code
	always_comb begin
		case (sel)
			mipsPkg::AluAdd: op = mipsPkg::FnAdd;
			mipsPkg::AluSlt: op = mipsPkg::FnSlt;
			mipsPkg::AluAnd: op = mipsPkg::FnAnd;
			mipsPkg::AluOr: op = mipsPkg::FnOr;
			mipsPkg::AluXor: op = mipsPkg::FnXor;
			default: op = funct; // AluFunct and AluLui fall through here
		endcase
	end

	always_comb begin
		if (sel == mipsPkg::AluLui) begin
			result = {b[15:0], 16'b0};
		end else begin
			case (op)
				mipsPkg::FnAdd: result = a + b; // Wraps
				mipsPkg::FnSub: result = a - b;
				mipsPkg::FnAnd: result = a & b;
				mipsPkg::FnOr: result = a | b;
				mipsPkg::FnXor: result = a ^ b;
				mipsPkg::FnNor: result = ~(a | b);
				mipsPkg::FnSlt: result = {31'b0, $signed(a) < $signed(b)};
				mipsPkg::FnSltu: result = {31'b0, a < b};
				mipsPkg::FnSll: result = a << shiftAmt;
				mipsPkg::FnSrl: result = a >> shiftAmt;
				mipsPkg::FnSra: result = $signed(a) >>> shiftAmt;
				default: result = '0;
			endcase
		end
	end

endmodule

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic CLK,
	input mipsPkg::regIdx readA,
	input mipsPkg::regIdx readB,
	output mipsPkg::dataWord dataA,
	output mipsPkg::dataWord dataB,
	input logic writeEn,
	input mipsPkg::regIdx writeIdx,
	input mipsPkg::dataWord writeData
);

	mipsPkg::dataWord regs [2**mipsPkg::RegIdxWidth];

	always_ff @(posedge CLK) begin
		if (writeEn && writeIdx != '0) begin
			regs[writeIdx] <= writeData;
		end
	end

	// R0 reads as zero
	assign dataA = (readA == '0) ? '0 : regs[readA];
	assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input logic CLK,
	input logic reset,
	input mipsPkg::instrWord instr,
	input logic memDone,
	output mipsPkg::ctrlWord ctrl
);

	mipsPkg::cpuState state;
	mipsPkg::cpuState nextState;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic isShift;

	assign opcode = instr.rType.opcode;
	assign funct = instr.rType.funct;
	assign isShift = (funct == mipsPkg::FnSll) || (funct == mipsPkg::FnSrl) ||
		(funct == mipsPkg::FnSra);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= mipsPkg::Idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state; // Wait states hold by default
		case (state)
			mipsPkg::Idle: nextState = mipsPkg::Fetch;
			mipsPkg::Fetch: if (memDone) nextState = mipsPkg::Decode;
			mipsPkg::Decode: begin
				case (opcode)
					mipsPkg::OpRType: nextState = mipsPkg::ExecReg;
					mipsPkg::OpAddi, mipsPkg::OpSlti, mipsPkg::OpAndi,
					mipsPkg::OpOri, mipsPkg::OpXori, mipsPkg::OpLui: nextState = mipsPkg::ExecImm;
					mipsPkg::OpBeq, mipsPkg::OpBne: nextState = mipsPkg::Branch;
					mipsPkg::OpLw, mipsPkg::OpSw: nextState = mipsPkg::MemAddr;
					default: nextState = mipsPkg::Fetch; // Unknown opcode is a no-op
				endcase
			end
			mipsPkg::ExecReg, mipsPkg::ExecImm, mipsPkg::Branch, mipsPkg::LoadWrite: begin
				nextState = mipsPkg::Fetch;
			end
			mipsPkg::MemAddr: begin
				nextState = (opcode == mipsPkg::OpLw) ? mipsPkg::LoadWait : mipsPkg::StoreWait;
			end
			mipsPkg::LoadWait: if (memDone) nextState = mipsPkg::LoadWrite;
			mipsPkg::StoreWait: if (memDone) nextState = mipsPkg::Fetch;
			default: nextState = mipsPkg::Idle;
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (state)
			mipsPkg::Fetch: begin
				ctrl.memValid = 1'b1; // Read at PC
				ctrl.irLoad = 1'b1;
				ctrl.pcWrite = 1'b1;
			end
			mipsPkg::ExecReg: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				ctrl.alu = mipsPkg::AluFunct;
				ctrl.aluSrc = isShift ? mipsPkg::SrcShamt : mipsPkg::SrcReg;
			end
			mipsPkg::ExecImm: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = mipsPkg::SrcZeroImm; // Logic ops and LUI
				case (opcode)
					mipsPkg::OpAddi: begin
						ctrl.alu = mipsPkg::AluAdd;
						ctrl.aluSrc = mipsPkg::SrcSignImm;
					end
					mipsPkg::OpSlti: begin
						ctrl.alu = mipsPkg::AluSlt;
						ctrl.aluSrc = mipsPkg::SrcSignImm;
					end
					mipsPkg::OpAndi: ctrl.alu = mipsPkg::AluAnd;
					mipsPkg::OpOri: ctrl.alu = mipsPkg::AluOr;
					mipsPkg::OpXori: ctrl.alu = mipsPkg::AluXor;
					default: ctrl.alu = mipsPkg::AluLui;
				endcase
			end
			mipsPkg::Branch: begin
				ctrl.pcWrite = 1'b1;
				ctrl.branch = (opcode == mipsPkg::OpBne) ? mipsPkg::BrNe : mipsPkg::BrEq;
			end
			mipsPkg::MemAddr: begin
				ctrl.alu = mipsPkg::AluAdd; // rs plus offset
				ctrl.aluSrc = mipsPkg::SrcSignImm;
				ctrl.marLoad = 1'b1;
			end
			mipsPkg::LoadWait: ctrl.memValid = 1'b1;
			mipsPkg::LoadWrite: begin
				ctrl.regWrite = 1'b1;
				ctrl.regIn = mipsPkg::InMem;
			end
			mipsPkg::StoreWait: begin
				ctrl.memValid = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			default: ctrl = '0; // Idle and Decode drive nothing
		endcase
	end

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input logic CLK,
	input logic reset,
	input mipsPkg::ctrlWord ctrl,
	input mipsPkg::memRsp busRsp,
	output mipsPkg::instrWord instr,
	output mipsPkg::memReq bus
);

	mipsPkg::memAddr pc;
	mipsPkg::memAddr mar;
	mipsPkg::memAddr pcTarget;
	mipsPkg::memAddr busAddr;
	mipsPkg::dataWord storeData;
	mipsPkg::dataWord mdr; // Load data
	mipsPkg::dataWord regA;
	mipsPkg::dataWord regB;
	mipsPkg::dataWord signImm;
	mipsPkg::dataWord zeroImm;
	mipsPkg::dataWord aluA;
	mipsPkg::dataWord aluB;
	mipsPkg::dataWord aluResult;
	mipsPkg::dataWord writeData;
	mipsPkg::regIdx writeIdx;
	logic branchTaken;
	logic loadCapture;

	assign signImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
	assign zeroImm = {16'b0, instr.iType.imm};

	// PC has already advanced when the branch state runs
	assign pcTarget = pc + {signImm[mipsPkg::AddrWidth-3:0], 2'b00};

	always_comb begin
		case (ctrl.branch)
			mipsPkg::BrEq: branchTaken = (regA == regB);
			mipsPkg::BrNe: branchTaken = (regA != regB);
			default: branchTaken = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.pcWrite) begin
			if (ctrl.branch == mipsPkg::BrNone) begin
				if (busRsp.done) pc <= pc + mipsPkg::memAddr'(4); // Fetch completes
			end else if (branchTaken) begin
				pc <= pcTarget;
			end
		end
	end

	assign loadCapture = ctrl.memValid && !ctrl.memWrite && !ctrl.irLoad && busRsp.done;

	always_ff @(posedge CLK) begin
		if (ctrl.irLoad && busRsp.done) begin
			instr <= busRsp.rdata;
		end
		if (ctrl.marLoad) begin
			mar <= aluResult[mipsPkg::AddrWidth-1:0];
			storeData <= regB; // rt for SW
		end
		if (loadCapture) begin
			mdr <= busRsp.rdata;
		end
	end

	// Shifts take rt as value and shamt as amount
	always_comb begin
		aluA = regA;
		case (ctrl.aluSrc)
			mipsPkg::SrcSignImm: aluB = signImm;
			mipsPkg::SrcZeroImm: aluB = zeroImm;
			mipsPkg::SrcShamt: begin
				aluA = regB;
				aluB = {27'b0, instr.rType.shamt};
			end
			default: aluB = regB;
		endcase
	end

	assign writeIdx = ctrl.regDstRd ? instr.rType.rd : instr.rType.rt;
	assign writeData = (ctrl.regIn == mipsPkg::InMem) ? mdr : aluResult;

	registerFile regs (
		.CLK(CLK),
		.readA(instr.rType.rs),
		.readB(instr.rType.rt),
		.dataA(regA),
		.dataB(regB),
		.writeEn(ctrl.regWrite),
		.writeIdx(writeIdx),
		.writeData(writeData)
	);

	alu mainAlu (
		.sel(ctrl.alu),
		.funct(instr.rType.funct),
		.a(aluA),
		.b(aluB),
		.result(aluResult)
	);

	assign busAddr = ctrl.pcWrite ? pc : mar; // Fetch reads at PC
	assign bus = '{valid: ctrl.memValid, write: ctrl.memWrite, addr: busAddr, wdata: storeData};

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
	input logic CLK,
	input logic reset,
	output mipsPkg::memReq bus,
	input mipsPkg::memRsp busRsp
);

	mipsPkg::instrWord instr;
	mipsPkg::ctrlWord ctrl;

	controlUnit control (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.memDone(busRsp.done),
		.ctrl(ctrl)
	);

	datapath dp (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl),
		.busRsp(busRsp),
		.instr(instr),
		.bus(bus)
	);

endmodule

// ==== tb/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int TimeoutCycles = 2000;

	logic CLK;
	logic reset;
	mipsPkg::memReq bus;
	mipsPkg::memRsp busRsp = '0;

	mipsPkg::dataWord mem [128];
	mipsPkg::dataWord preset [int]; // Data words by word index
	mipsPkg::dataWord prog [$];
	mipsPkg::memAddr readAddrs [$];
	mipsPkg::memAddr storeAddrs [$];
	mipsPkg::dataWord storeWords [$];
	mipsPkg::memReq heldReq;
	logic [31:0] lfsr;
	logic useDelay;
	logic pending = 1'b0;
	logic resetSeen = 1'b1;
	int waitLeft = 0;

	mipsCore uut (.CLK(CLK), .reset(reset), .bus(bus), .busRsp(busRsp));

	always #5 CLK = ~CLK;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			stopWithFailure($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	function automatic logic randomBit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // Galois step
		return lfsr[0];
	endfunction

	function automatic mipsPkg::dataWord encodeR(input int rs, input int rt, input int rd,
		input int shamt, input logic [5:0] funct);
		return {mipsPkg::OpRType, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
	endfunction

	function automatic mipsPkg::dataWord encodeI(input logic [5:0] op, input int rs, input int rt,
		input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	always @(posedge CLK) resetSeen <= reset;

	// Memory answers on the falling edge
	always @(negedge CLK) begin
		busRsp.done = 1'b0;
		if (resetSeen) begin
			pending = 1'b0;
			if (bus.valid) stopWithFailure("Bus request was raised while reset was high");
		end else if (bus.valid) begin
			if (!pending) begin
				pending = 1'b1;
				heldReq = bus;
				waitLeft = useDelay ? {randomBit(), randomBit()} : 0;
			end
			compare("bus request", bus, heldReq); // Must hold while waiting
			if (waitLeft == 0) begin
				pending = 1'b0;
				busRsp.done = 1'b1;
				if (bus.write) begin
					mem[bus.addr[8:2]] = bus.wdata;
					storeAddrs.push_back(bus.addr);
					storeWords.push_back(bus.wdata);
				end else begin
					busRsp.rdata = mem[bus.addr[8:2]];
					readAddrs.push_back(bus.addr);
				end
			end else begin
				waitLeft--;
			end
		end
	end

	task automatic startRun(input logic delayed);
		@(negedge CLK);
		reset = 1'b1;
		@(negedge CLK);
		useDelay = delayed;
		for (int i = 0; i < 128; i++) begin
			mem[i] = 32'hfc000000 | i; // Undefined opcode tagged with its index
		end
		foreach (prog[i]) mem[i] = prog[i];
		foreach (preset[i]) mem[i] = preset[i];
		repeat (2) @(negedge CLK);
		readAddrs.delete();
		storeAddrs.delete();
		storeWords.delete();
		reset = 1'b0;
	endtask

	task automatic waitForReads(input int count);
		int cycles = 0;
		while (readAddrs.size() < count && cycles < TimeoutCycles) begin
			@(posedge CLK);
			cycles++;
		end
		if (readAddrs.size() < count) stopWithFailure("Timed out waiting for bus reads");
	endtask

	task automatic waitForStores(input int count);
		int cycles = 0;
		while (storeAddrs.size() < count && cycles < TimeoutCycles) begin
			@(posedge CLK);
			cycles++;
		end
		if (storeAddrs.size() < count) stopWithFailure("Timed out waiting for bus stores");
	endtask

	task automatic verifyRead(input int k, input int addr);
		compare($sformatf("fetch %0d bus.addr", k), readAddrs[k], addr);
	endtask

	task automatic checkStore(input int k, input int addr, input mipsPkg::dataWord data);
		compare($sformatf("store %0d bus.addr", k), storeAddrs[k], addr);
		compare($sformatf("store %0d bus.wdata", k), storeWords[k], data);
	endtask

	// Two loads, then each R-type op stored from 0x180 upward
	task automatic buildArith(input mipsPkg::dataWord a, input mipsPkg::dataWord b);
		logic [5:0] functs [11] = '{mipsPkg::FnAdd, mipsPkg::FnSub, mipsPkg::FnAnd,
			mipsPkg::FnOr, mipsPkg::FnXor, mipsPkg::FnNor, mipsPkg::FnSlt, mipsPkg::FnSltu,
			mipsPkg::FnSll, mipsPkg::FnSrl, mipsPkg::FnSra};
		prog = {encodeI(mipsPkg::OpLw, 0, 1, 'h100), encodeI(mipsPkg::OpLw, 0, 2, 'h104)};
		foreach (functs[i]) begin
			if (i < 8) prog.push_back(encodeR(1, 2, 3, 0, functs[i]));
			else prog.push_back(encodeR(0, 1, 3, 4, functs[i])); // Shift r1 by 4
			prog.push_back(encodeI(mipsPkg::OpSw, 0, 3, 'h180 + 4 * i));
		end
		prog.push_back(encodeI(mipsPkg::OpBeq, 0, 0, -1));
		preset.delete();
		preset[64] = a;
		preset[65] = b;
	endtask

	task automatic fetchSequence();
		int expected [6] = '{0, 4, 8, 12, 12, 12};
		prog = {encodeI(mipsPkg::OpAddi, 0, 1, 5), encodeI(mipsPkg::OpAddi, 0, 2, 6),
			encodeR(1, 2, 3, 0, mipsPkg::FnAdd), encodeI(mipsPkg::OpBeq, 0, 0, -1)};
		preset.delete();
		startRun(1'b0);
		waitForReads(6);
		foreach (expected[i]) verifyRead(i, expected[i]);
	endtask

	task automatic rTypeResults();
		mipsPkg::dataWord expected [11] = '{32'h80000103, 32'h800000dd, 32'h00000010,
			32'h800000f3, 32'h800000e3, 32'h7fffff0c, 32'd1, 32'd0,
			32'h00000f00, 32'h0800000f, 32'hf800000f};
		buildArith(32'h800000f0, 32'h00000013);
		startRun(1'b0);
		waitForStores(11);
		foreach (expected[i]) checkStore(i, 'h180 + 4 * i, expected[i]);
	endtask

	task automatic immediateResults();
		mipsPkg::dataWord expected [8] = '{32'hfffffffd, 32'd1, 32'd0, 32'h0000f0f0,
			32'h00008001, 32'hffff0002, 32'h82340000, 32'd0};
		prog = {encodeI(mipsPkg::OpAddi, 0, 1, -3), encodeI(mipsPkg::OpSlti, 1, 2, -2),
			encodeI(mipsPkg::OpSlti, 0, 3, -1), encodeI(mipsPkg::OpAndi, 1, 4, 'hf0f0),
			encodeI(mipsPkg::OpOri, 0, 5, 'h8001), encodeI(mipsPkg::OpXori, 1, 6, 'hffff),
			encodeI(mipsPkg::OpLui, 0, 7, 'h8234), encodeI(mipsPkg::OpAddi, 0, 0, 7)};
		for (int i = 0; i < 8; i++) begin
			prog.push_back(encodeI(mipsPkg::OpSw, 0, (i + 1) % 8, 'h180 + 4 * i)); // r0 last
		end
		prog.push_back(encodeI(mipsPkg::OpBeq, 0, 0, -1));
		preset.delete();
		startRun(1'b0);
		waitForStores(8);
		foreach (expected[i]) checkStore(i, 'h180 + 4 * i, expected[i]);
	endtask

	task automatic loadStoreRoundTrip();
		prog = {encodeI(mipsPkg::OpAddi, 0, 1, 'h100), encodeI(mipsPkg::OpLw, 1, 2, 'h10),
			encodeI(mipsPkg::OpAddi, 0, 3, 'h180), encodeI(mipsPkg::OpSw, 3, 2, -8),
			encodeI(mipsPkg::OpSw, 3, 2, 4), encodeI(mipsPkg::OpBeq, 0, 0, -1)};
		preset.delete();
		preset[68] = 32'hcafe1234; // Byte 0x110
		startRun(1'b0);
		waitForStores(2);
		checkStore(0, 'h178, 32'hcafe1234);
		checkStore(1, 'h184, 32'hcafe1234);
	endtask

	task automatic branchTargets();
		int expected [8] = '{0, 4, 8, 20, 24, 28, 36, 36};
		prog = {encodeI(mipsPkg::OpAddi, 0, 1, 1), encodeI(mipsPkg::OpAddi, 0, 2, 1),
			encodeI(mipsPkg::OpBeq, 1, 2, 2), encodeI(mipsPkg::OpAddi, 0, 3, 9),
			encodeI(mipsPkg::OpAddi, 0, 3, 9), encodeI(mipsPkg::OpBne, 1, 2, 5),
			encodeI(mipsPkg::OpBeq, 1, 0, 3), encodeI(mipsPkg::OpBne, 1, 0, 1),
			encodeI(mipsPkg::OpAddi, 0, 3, 9), encodeI(mipsPkg::OpBeq, 0, 0, -1)};
		preset.delete();
		startRun(1'b0);
		waitForReads(8);
		foreach (expected[i]) verifyRead(i, expected[i]);
	endtask

	task automatic backPressureRun();
		mipsPkg::dataWord expected [11] = '{32'h7ffe8004, 32'h7fff7ffe, 32'h7fff0001,
			32'hffff8003, 32'h80008002, 32'h00007ffc, 32'd0, 32'd1,
			32'hfff00010, 32'h07fff000, 32'h07fff000};
		buildArith(32'h7fff0001, 32'hffff8003);
		startRun(1'b0);
		waitForStores(11);
		foreach (expected[i]) checkStore(i, 'h180 + 4 * i, expected[i]);
		startRun(1'b1); // Same program with random wait cycles
		waitForStores(11);
		foreach (expected[i]) checkStore(i, 'h180 + 4 * i, expected[i]);
	endtask

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		lfsr = 32'ha22a;
		useDelay = 1'b0;
		fetchSequence();
		rTypeResults();
		immediateResults();
		loadStoreRoundTrip();
		branchTargets();
		backPressureRun();
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/mipsPkg.sv
logic/alu.sv
logic/registerFile.sv
logic/controlUnit.sv
logic/datapath.sv
logic/mipsCore.sv
tb/mipsCoreTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = mipsCoreTb
FILELIST = vlog.f
PASS = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS)"

clean:
	rm -rf obj_dir
